//--- bot/bot_cb_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module bot_cb_decoder (
  input  logic                  clock,
  input  logic                  reset,

  input  logic                  cb_start_i,
  input  bot_pkg::cbw_info_t    cbw_info_i,

  input  logic                  cb_valid_i,
  input  bot_pkg::stream_beat_t cb_beat_i,
  output logic                  cb_ready_o,

  output logic                  cmd_req_o,
  output bot_pkg::scsi_cmd_t    cmd_o,
  input  logic                  cmd_ack_i
);

  typedef enum logic [1:0] {
    DEC_IDLE,
    DEC_COLLECT,
    DEC_REQ,
    DEC_RELEASE
  } dec_state_e;

  dec_state_e        state;
  logic [4:0]        cnt;
  logic [7:0]        op_raw;
  logic [31:0]       lba;
  logic [15:0]       blocks;
  logic              beat_xfer;
  logic              rw_cmd;
  bot_pkg::scsi_op_e op;

  assign cb_ready_o = state == DEC_COLLECT;
  assign cmd_req_o  = state == DEC_REQ;
  assign beat_xfer  = cb_valid_i && cb_ready_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= DEC_IDLE;
      cnt   <= 5'd0;
    end else begin
      case (state)
        DEC_IDLE: begin
          cnt <= 5'd0;
          if (cb_start_i) state <= DEC_COLLECT;
        end
        DEC_COLLECT: begin
          if (beat_xfer) begin
            if (cnt != 5'd31) cnt <= cnt + 5'd1;
            if (cb_beat_i.last) state <= DEC_REQ;
          end
        end
        DEC_REQ:     if (cmd_ack_i) state <= DEC_RELEASE;
        DEC_RELEASE: if (!cmd_ack_i) state <= DEC_IDLE;
        default:     state <= DEC_IDLE;
      endcase
    end
  end

  // Missing bytes read as zero, bytes beyond cb_len are ignored
  always_ff @(posedge clock) begin
    if (cb_start_i) begin
      op_raw <= 8'd0;
      lba    <= 32'd0;
      blocks <= 16'd0;
    end else if (beat_xfer && cnt < cbw_info_i.cb_len) begin
      case (cnt)
        5'd0: op_raw        <= cb_beat_i.data;
        5'd2: lba[31:24]    <= cb_beat_i.data;
        5'd3: lba[23:16]    <= cb_beat_i.data;
        5'd4: lba[15:8]     <= cb_beat_i.data;
        5'd5: lba[7:0]      <= cb_beat_i.data;
        5'd7: blocks[15:8]  <= cb_beat_i.data;
        5'd8: blocks[7:0]   <= cb_beat_i.data;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (op_raw)
      8'h00:   op = bot_pkg::OP_TEST_UNIT_READY;
      8'h12:   op = bot_pkg::OP_INQUIRY;
      8'h28:   op = bot_pkg::OP_READ_10;
      8'h2A:   op = bot_pkg::OP_WRITE_10;
      default: op = bot_pkg::OP_OTHER;
    endcase
  end

  assign rw_cmd       = op == bot_pkg::OP_READ_10 || op == bot_pkg::OP_WRITE_10;
  assign cmd_o.info   = cbw_info_i;
  assign cmd_o.op     = op;
  assign cmd_o.opcode = op_raw;
  assign cmd_o.lba    = rw_cmd ? lba : 32'd0;
  assign cmd_o.blocks = rw_cmd ? blocks : 16'd0;

  a_req_holds_for_ack : assert property (
    @(posedge clock) disable iff (reset)
    $fell(cmd_req_o) |-> $past(cmd_ack_i)
  );

  // Header fields come from the parser, so this also covers its hold
  a_cmd_stable : assert property (
    @(posedge clock) disable iff (reset)
    cmd_req_o && !cmd_ack_i |=> $stable(cmd_o)
  );

endmodule

`default_nettype wire

//--- bot/bot_cbw_parser.sv
`timescale 1ns/10ps
`default_nettype none

module bot_cbw_parser (
  input  logic                 clock,
  input  logic                 reset,

  // Bulk-Out stream
  input  logic                 usb_rx_valid_i,
  input  bot_pkg::stream_beat_t usb_rx_beat_i,
  output logic                 usb_rx_ready_o,

  // Command block towards the skid buffer
  input  logic                 skid_ready_i,
  output logic                 skid_valid_o,

  input  logic                 csw_sent_i,
  output logic                 status_phase_o,
  output logic                 cb_start_o,
  output bot_pkg::cbw_info_t   cbw_info_o,
  output logic                 error_o
);

  bot_pkg::parser_state_e state;
  logic                   beat_xfer;
  logic                   reject;
  logic [7:0]             rx_byte;

  assign rx_byte = usb_rx_beat_i.data;

  always_comb begin
    case (state)
      bot_pkg::ST_IDLE,
      bot_pkg::ST_STATUS: usb_rx_ready_o = 1'b0;
      bot_pkg::ST_CMD:    usb_rx_ready_o = skid_ready_i;
      default:            usb_rx_ready_o = 1'b1;
    endcase
  end

  assign beat_xfer      = usb_rx_valid_i && usb_rx_ready_o;
  assign skid_valid_o   = usb_rx_valid_i && (state == bot_pkg::ST_CMD);
  assign status_phase_o = state == bot_pkg::ST_STATUS;

  // Field checks for the header byte currently on the stream
  always_comb begin
    case (state)
      bot_pkg::ST_SIG0:  reject = rx_byte != bot_pkg::CBW_SIGNATURE[7:0];
      bot_pkg::ST_SIG1:  reject = rx_byte != bot_pkg::CBW_SIGNATURE[15:8];
      bot_pkg::ST_SIG2:  reject = rx_byte != bot_pkg::CBW_SIGNATURE[23:16];
      bot_pkg::ST_SIG3:  reject = rx_byte != bot_pkg::CBW_SIGNATURE[31:24];
      bot_pkg::ST_FLAGS: reject = rx_byte[6:0] != 7'd0;
      bot_pkg::ST_LUN:   reject = rx_byte[7:4] != 4'd0;
      bot_pkg::ST_CBLEN: reject = rx_byte == 8'd0 || rx_byte > bot_pkg::CB_MAX_LEN;
      default:           reject = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= bot_pkg::ST_IDLE;
      cb_start_o <= 1'b0;
      error_o    <= 1'b0;
    end else begin
      cb_start_o <= 1'b0;
      case (state)
        bot_pkg::ST_IDLE: begin
          state <= bot_pkg::ST_SIG0;
        end

        bot_pkg::ST_CMD: begin
          // Bytes past the declared length still belong to this command
          if (beat_xfer && usb_rx_beat_i.last) begin
            state <= bot_pkg::ST_STATUS;
          end
        end

        bot_pkg::ST_STATUS: begin
          if (csw_sent_i) begin
            state <= bot_pkg::ST_IDLE;
          end
        end

        bot_pkg::ST_FAIL: begin
          if (beat_xfer && usb_rx_beat_i.last) begin
            state <= bot_pkg::ST_IDLE;
          end
        end

        default: begin
          if (beat_xfer) begin
            if (state == bot_pkg::ST_SIG0) begin
              error_o <= 1'b0;
            end
            if (reject) begin
              error_o <= 1'b1;
              // A rejected byte may already close the packet
              state   <= usb_rx_beat_i.last ? bot_pkg::ST_IDLE : bot_pkg::ST_FAIL;
            end else begin
              state      <= bot_pkg::parser_state_e'(state + 5'd1);
              cb_start_o <= state == bot_pkg::ST_CBLEN;
            end
          end
        end
      endcase
    end
  end

  // Header capture with little-endian multi-byte fields
  always_ff @(posedge clock) begin
    if (beat_xfer) begin
      case (state)
        bot_pkg::ST_TAG0:  cbw_info_o.tag[7:0]        <= rx_byte;
        bot_pkg::ST_TAG1:  cbw_info_o.tag[15:8]       <= rx_byte;
        bot_pkg::ST_TAG2:  cbw_info_o.tag[23:16]      <= rx_byte;
        bot_pkg::ST_TAG3:  cbw_info_o.tag[31:24]      <= rx_byte;
        bot_pkg::ST_LEN0:  cbw_info_o.data_len[7:0]   <= rx_byte;
        bot_pkg::ST_LEN1:  cbw_info_o.data_len[15:8]  <= rx_byte;
        bot_pkg::ST_LEN2:  cbw_info_o.data_len[23:16] <= rx_byte;
        bot_pkg::ST_LEN3:  cbw_info_o.data_len[31:24] <= rx_byte;
        bot_pkg::ST_FLAGS: cbw_info_o.dir             <= rx_byte[7];
        bot_pkg::ST_LUN:   cbw_info_o.lun             <= rx_byte[3:0];
        bot_pkg::ST_CBLEN: cbw_info_o.cb_len          <= rx_byte[4:0];
        default: ;
      endcase
    end
  end

  // Header fields stay put while the command and its CSW are in flight
  a_info_held : assert property (
    @(posedge clock) disable iff (reset)
    (state == bot_pkg::ST_CMD || state == bot_pkg::ST_STATUS) |=> $stable(cbw_info_o)
  );

endmodule

`default_nettype wire

//--- bot/bot_csw_builder.sv
`timescale 1ns/10ps
`default_nettype none

module bot_csw_builder (
  input  logic                  clock,
  input  logic                  reset,

  input  bot_pkg::cbw_info_t    cbw_info_i,
  input  logic                  status_phase_i,

  input  logic                  done_req_i,
  input  bot_pkg::scsi_status_t done_status_i,
  output logic                  done_ack_o,

  output logic                  usb_tx_valid_o,
  output bot_pkg::stream_beat_t usb_tx_beat_o,
  input  logic                  usb_tx_ready_i,

  output logic                  csw_sent_o
);

  typedef enum logic [1:0] {
    CSW_IDLE,
    CSW_LOAD,
    CSW_SEND
  } csw_state_e;

  csw_state_e            state;
  logic [3:0]            cnt;
  bot_pkg::scsi_status_t status_q;
  logic [31:0]           residue;
  logic [103:0]          csw_bytes;
  logic                  beat_xfer;

  assign usb_tx_valid_o = state == CSW_SEND;
  assign beat_xfer      = usb_tx_valid_o && usb_tx_ready_i;
  assign csw_sent_o     = beat_xfer && cnt == 4'd12;

  // Whole wrapper in wire order, byte 0 in the low bits
  assign csw_bytes = {status_q.status, residue, cbw_info_i.tag, bot_pkg::CSW_SIGNATURE};

  assign usb_tx_beat_o.data = csw_bytes[{cnt, 3'b000} +: 8];
  assign usb_tx_beat_o.last = cnt == 4'd12;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= CSW_IDLE;
      done_ack_o <= 1'b0;
      cnt        <= 4'd0;
    end else begin
      if (done_ack_o && !done_req_i) begin
        done_ack_o <= 1'b0;
      end
      case (state)
        CSW_IDLE: begin
          if (status_phase_i && done_req_i && !done_ack_o) begin
            done_ack_o <= 1'b1;
            state      <= CSW_LOAD;
          end
        end
        CSW_LOAD: begin
          cnt   <= 4'd0;
          state <= CSW_SEND;
        end
        CSW_SEND: begin
          if (beat_xfer) begin
            if (cnt == 4'd12) state <= CSW_IDLE;
            else cnt <= cnt + 4'd1;
          end
        end
        default: state <= CSW_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == CSW_IDLE && status_phase_i && done_req_i && !done_ack_o) begin
      status_q <= done_status_i;
    end
    // Residue saturates at zero when more was moved than requested
    if (state == CSW_LOAD) begin
      if (status_q.transferred > cbw_info_i.data_len) begin
        residue <= 32'd0;
      end else begin
        residue <= cbw_info_i.data_len - status_q.transferred;
      end
    end
  end

endmodule

`default_nettype wire

//--- common/bot_pkg.sv
`default_nettype none

package bot_pkg;

  // Wrapper signatures, first byte on the wire in bits [7:0]
  localparam logic [31:0] CBW_SIGNATURE = 32'h4342_5355;
  localparam logic [31:0] CSW_SIGNATURE = 32'h5342_5355;

  // Largest legal SCSI command block
  localparam logic [7:0] CB_MAX_LEN = 8'd16;

  // Header states are kept in wire order, the parser steps through them by +1
  typedef enum logic [4:0] {
    ST_IDLE,
    ST_SIG0,
    ST_SIG1,
    ST_SIG2,
    ST_SIG3,
    ST_TAG0,
    ST_TAG1,
    ST_TAG2,
    ST_TAG3,
    ST_LEN0,
    ST_LEN1,
    ST_LEN2,
    ST_LEN3,
    ST_FLAGS,
    ST_LUN,
    ST_CBLEN,
    ST_CMD,
    ST_STATUS,
    ST_FAIL
  } parser_state_e;

  typedef enum logic [7:0] {
    OP_TEST_UNIT_READY = 8'h00,
    OP_INQUIRY         = 8'h12,
    OP_READ_10         = 8'h28,
    OP_WRITE_10        = 8'h2A,
    OP_OTHER           = 8'hFF
  } scsi_op_e;

  typedef struct packed {
    logic [31:0] tag;
    logic [31:0] data_len;
    logic        dir;       // 1 is device to host
    logic [3:0]  lun;
    logic [4:0]  cb_len;
  } cbw_info_t;

  typedef struct packed {
    cbw_info_t   info;
    scsi_op_e    op;
    logic [7:0]  opcode;
    logic [31:0] lba;
    logic [15:0] blocks;
  } scsi_cmd_t;

  // Status byte: 0 passed, 1 failed, 2 phase error
  typedef struct packed {
    logic [7:0]  status;
    logic [31:0] transferred;
  } scsi_status_t;

  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } stream_beat_t;

endpackage

`default_nettype wire

//--- design/axis_skid.sv
`timescale 1ns/10ps
`default_nettype none

module axis_skid #(
  parameter int WIDTH = 9
) (
  input  logic             clock,
  input  logic             reset,

  input  logic             s_valid_i,
  input  logic [WIDTH-1:0] s_data_i,
  output logic             s_ready_o,

  output logic             m_valid_o,
  output logic [WIDTH-1:0] m_data_o,
  input  logic             m_ready_i
);

  logic             skid_valid;
  logic [WIDTH-1:0] skid_data;
  logic             out_free;

  // Output register can take a new beat this cycle
  assign out_free  = m_ready_i || !m_valid_o;
  assign s_ready_o = !skid_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      m_valid_o  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      if (skid_valid) begin
        m_valid_o  <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        m_valid_o <= s_valid_i;
      end
    end else if (s_valid_i && s_ready_o) begin
      // Output stalled, park the incoming beat
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (out_free) begin
      m_data_o <= skid_valid ? skid_data : s_data_i;
    end else if (s_valid_i && s_ready_o) begin
      skid_data <= s_data_i;
    end
  end

  a_hold_stable : assert property (
    @(posedge clock) disable iff (reset)
    m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_data_o)
  );

endmodule

`default_nettype wire

//--- design/bot_top.sv
`timescale 1ns/10ps
`default_nettype none

module bot_top (
  input  logic                  clock,
  input  logic                  reset,

  // Bulk-Out stream carrying CBWs
  input  logic                  usb_rx_valid_i,
  output logic                  usb_rx_ready_o,
  input  bot_pkg::stream_beat_t usb_rx_beat_i,

  // Bulk-In stream carrying CSWs
  output logic                  usb_tx_valid_o,
  input  logic                  usb_tx_ready_i,
  output bot_pkg::stream_beat_t usb_tx_beat_o,

  // Command handoff to the SCSI controller
  output logic                  cmd_req_o,
  output bot_pkg::scsi_cmd_t    cmd_o,
  input  logic                  cmd_ack_i,

  // Completion from the SCSI controller
  input  logic                  done_req_i,
  input  bot_pkg::scsi_status_t done_status_i,
  output logic                  done_ack_o,

  output logic                  error_o
);

  localparam int BEAT_W = $bits(bot_pkg::stream_beat_t);

  logic                  skid_valid;
  logic                  skid_ready;
  logic                  cb_valid;
  logic                  cb_ready;
  bot_pkg::stream_beat_t cb_beat;
  bot_pkg::cbw_info_t    cbw_info;
  logic                  cb_start;
  logic                  status_phase;
  logic                  csw_sent;

  bot_cbw_parser i_parser (
    .clock          (clock),
    .reset          (reset),
    .usb_rx_valid_i (usb_rx_valid_i),
    .usb_rx_beat_i  (usb_rx_beat_i),
    .usb_rx_ready_o (usb_rx_ready_o),
    .skid_ready_i   (skid_ready),
    .skid_valid_o   (skid_valid),
    .csw_sent_i     (csw_sent),
    .status_phase_o (status_phase),
    .cb_start_o     (cb_start),
    .cbw_info_o     (cbw_info),
    .error_o        (error_o)
  );

  // Command-block bytes go straight from the Bulk-Out stream into the skid
  axis_skid #(
    .WIDTH (BEAT_W)
  ) i_skid (
    .clock     (clock),
    .reset     (reset),
    .s_valid_i (skid_valid),
    .s_data_i  (usb_rx_beat_i),
    .s_ready_o (skid_ready),
    .m_valid_o (cb_valid),
    .m_data_o  (cb_beat),
    .m_ready_i (cb_ready)
  );

  bot_cb_decoder i_decoder (
    .clock      (clock),
    .reset      (reset),
    .cb_start_i (cb_start),
    .cbw_info_i (cbw_info),
    .cb_valid_i (cb_valid),
    .cb_beat_i  (cb_beat),
    .cb_ready_o (cb_ready),
    .cmd_req_o  (cmd_req_o),
    .cmd_o      (cmd_o),
    .cmd_ack_i  (cmd_ack_i)
  );

  bot_csw_builder i_csw (
    .clock          (clock),
    .reset          (reset),
    .cbw_info_i     (cbw_info),
    .status_phase_i (status_phase),
    .done_req_i     (done_req_i),
    .done_status_i  (done_status_i),
    .done_ack_o     (done_ack_o),
    .usb_tx_valid_o (usb_tx_valid_o),
    .usb_tx_beat_o  (usb_tx_beat_o),
    .usb_tx_ready_i (usb_tx_ready_i),
    .csw_sent_o     (csw_sent)
  );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log
rm -f sim.log
verilator --binary -Wno-fatal --assert --top-module bot_tb -f src.f -o bot_sim > sim.log 2>&1 &&
  ./obj_dir/bot_sim >> sim.log 2>&1 ||
  echo "Build or simulation ended abnormally" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || grep -q "TEST PASSED" sim.log

//--- src.f
common/bot_pkg.sv
design/axis_skid.sv
bot/bot_cbw_parser.sv
bot/bot_cb_decoder.sv
bot/bot_csw_builder.sv
design/bot_top.sv
tests/bot_checker.sv
tests/bot_tb.sv

//--- tests/bot_checker.sv
`timescale 1ns/10ps
`default_nettype none

module bot_checker (
  input logic                  clock,
  input logic                  reset,
  input logic                  usb_rx_valid_i,
  input logic                  usb_rx_ready_i,
  input bot_pkg::stream_beat_t usb_rx_beat_i,
  input logic                  usb_tx_valid_i,
  input logic                  usb_tx_ready_i,
  input bot_pkg::stream_beat_t usb_tx_beat_i,
  input logic                  cmd_req_i,
  input bot_pkg::scsi_cmd_t    cmd_i,
  input logic                  cmd_ack_i,
  input logic                  done_req_i,
  input bot_pkg::scsi_status_t done_status_i,
  input logic                  done_ack_i,
  input logic                  error_i,
  input logic                  end_check_i
);

  int                    errors = 0;
  int                    cmd_count = 0;
  int                    reject_count = 0;
  logic [7:0]            pkt [0:30];
  int                    rx_idx;
  int                    release_step;
  bot_pkg::scsi_cmd_t    cmd_q [$];
  bot_pkg::cbw_info_t    info_q [$];
  logic [7:0]            tx_q [$];
  logic [7:0]            csw_exp [0:12];
  logic                  err_due;
  logic                  err_exp;
  logic                  end_done = 1'b0;
  logic                  reset_q = 1'b0;
  logic                  cmd_req_q;
  logic                  cmd_ack_q;
  logic                  done_req_q;
  logic                  done_ack_q;
  logic                  tx_valid_q;
  logic                  tx_ready_q;
  bot_pkg::scsi_cmd_t    cmd_prev;
  bot_pkg::scsi_cmd_t    exp_cmd;
  bot_pkg::stream_beat_t tx_prev;
  bot_pkg::cbw_info_t    info;
  logic [31:0]           residue;
  logic [7:0]            exp_byte;

  task automatic report_value(input string name, input logic [255:0] exp, input logic [255:0] act);
    errors++;
    $display("ERROR %0t %s expected %0h actual %0h", $time, name, exp, act);
  endtask

  task automatic report_fault(input string msg);
    errors++;
    $display("ERROR %0t %s", $time, msg);
  endtask

  function automatic logic cbw_ok();
    return pkt[0] == 8'h55 && pkt[1] == 8'h53 && pkt[2] == 8'h42 && pkt[3] == 8'h43 &&
           pkt[12][6:0] == 7'd0 && pkt[13][7:4] == 4'd0 && pkt[14] >= 8'd1 && pkt[14] <= 8'd16;
  endfunction

  // Bytes past the declared length count as zero
  function automatic logic [7:0] cb_byte(input int i);
    return (i < int'(pkt[14])) ? pkt[15+i] : 8'h00;
  endfunction

  function automatic bot_pkg::scsi_cmd_t cbw_to_cmd();
    bot_pkg::scsi_cmd_t c;
    c.info.tag      = {pkt[7], pkt[6], pkt[5], pkt[4]};
    c.info.data_len = {pkt[11], pkt[10], pkt[9], pkt[8]};
    c.info.dir      = pkt[12][7];
    c.info.lun      = pkt[13][3:0];
    c.info.cb_len   = pkt[14][4:0];
    c.opcode        = cb_byte(0);
    case (c.opcode)
      8'h00:   c.op = bot_pkg::OP_TEST_UNIT_READY;
      8'h12:   c.op = bot_pkg::OP_INQUIRY;
      8'h28:   c.op = bot_pkg::OP_READ_10;
      8'h2A:   c.op = bot_pkg::OP_WRITE_10;
      default: c.op = bot_pkg::OP_OTHER;
    endcase
    if (c.op == bot_pkg::OP_READ_10 || c.op == bot_pkg::OP_WRITE_10) begin
      c.lba    = {cb_byte(2), cb_byte(3), cb_byte(4), cb_byte(5)};
      c.blocks = {cb_byte(7), cb_byte(8)};
    end else begin
      c.lba    = 32'd0;
      c.blocks = 16'd0;
    end
    return c;
  endfunction

  always @(posedge clock) begin
    if (reset) begin
      rx_idx       = 0;
      release_step = 0;
      err_due      = 1'b0;
      if (reset_q && (cmd_req_i || done_ack_i || usb_tx_valid_i || usb_rx_ready_i || error_i)) begin
        report_fault("a control output is high during reset");
      end
    end else begin
      if (release_step == 0) begin
        if (cmd_req_i || done_ack_i || usb_tx_valid_i || usb_rx_ready_i || error_i) begin
          report_fault("a control output is high right after reset");
        end
        release_step = 1;
      end else if (release_step == 1) begin
        if (usb_rx_ready_i !== 1'b1) report_value("usb_rx_ready_o", 1, usb_rx_ready_i);
        release_step = 2;
      end

      if (err_due) begin
        if (error_i !== err_exp) report_value("error_o", err_exp, error_i);
        err_due = 1'b0;
      end

      // Rebuild each CBW from the accepted Bulk-Out beats
      if (usb_rx_valid_i && usb_rx_ready_i) begin
        if (rx_idx < 31) pkt[rx_idx] = usb_rx_beat_i.data;
        rx_idx++;
        if (usb_rx_beat_i.last) begin
          if (rx_idx != 31) begin
            report_fault("a CBW of the wrong length was accepted on usb_rx");
          end else begin
            err_exp = !cbw_ok();
            err_due = 1'b1;
            if (err_exp) reject_count++;
            else cmd_q.push_back(cbw_to_cmd());
          end
          rx_idx = 0;
        end
      end

      if (cmd_req_i && !cmd_req_q) begin
        if (cmd_ack_i) report_fault("cmd_req_o rose while cmd_ack_i was still high");
        if (cmd_q.size() == 0) begin
          report_fault("a command was offered without a valid CBW");
        end else begin
          exp_cmd = cmd_q.pop_front();
          if (cmd_i !== exp_cmd) report_value("cmd_o", exp_cmd, cmd_i);
          info_q.push_back(exp_cmd.info);
          cmd_count++;
        end
      end
      if (cmd_req_q && !cmd_ack_q && cmd_req_i && cmd_i !== cmd_prev) begin
        report_value("cmd_o", cmd_prev, cmd_i);
      end
      if (cmd_req_q && !cmd_req_i && !cmd_ack_q) report_fault("cmd_req_o fell before cmd_ack_i");

      if (done_ack_i && !done_ack_q) begin
        if (!done_req_q) report_fault("done_ack_o rose without done_req_i");
        if (info_q.size() == 0) begin
          report_fault("status was accepted with no command outstanding");
        end else begin
          info    = info_q.pop_front();
          residue = (done_status_i.transferred > info.data_len) ? 32'd0 :
                    info.data_len - done_status_i.transferred;
          csw_exp = '{8'h55, 8'h53, 8'h42, 8'h53,
                      info.tag[7:0], info.tag[15:8], info.tag[23:16], info.tag[31:24],
                      residue[7:0], residue[15:8], residue[23:16], residue[31:24],
                      done_status_i.status};
          foreach (csw_exp[i]) tx_q.push_back(csw_exp[i]);
        end
      end
      if (done_ack_q && !done_ack_i && done_req_q) begin
        report_fault("done_ack_o fell while done_req_i was high");
      end

      if (tx_valid_q && !tx_ready_q && (!usb_tx_valid_i || usb_tx_beat_i !== tx_prev)) begin
        report_value("usb_tx_beat_o", tx_prev, usb_tx_beat_i);
      end
      if (usb_tx_valid_i && usb_tx_ready_i) begin
        if (tx_q.size() == 0) begin
          report_fault("a usb_tx beat was sent with no CSW expected");
        end else begin
          exp_byte = tx_q.pop_front();
          if (usb_tx_beat_i.data !== exp_byte) begin
            report_value("usb_tx_beat_o.data", exp_byte, usb_tx_beat_i.data);
          end
          if (usb_tx_beat_i.last !== (tx_q.size() == 0)) begin
            report_value("usb_tx_beat_o.last", tx_q.size() == 0, usb_tx_beat_i.last);
          end
        end
      end

      if (end_check_i && !end_done) begin
        end_done = 1'b1;
        if (cmd_q.size() != 0) report_fault("valid CBWs never produced a command");
        if (info_q.size() != 0 || tx_q.size() != 0) report_fault("a CSW was never sent in full");
      end
    end
    reset_q    = reset;
    cmd_req_q  = cmd_req_i;
    cmd_ack_q  = cmd_ack_i;
    done_req_q = done_req_i;
    done_ack_q = done_ack_i;
    tx_valid_q = usb_tx_valid_i;
    tx_ready_q = usb_tx_ready_i;
    cmd_prev   = cmd_i;
    tx_prev    = usb_tx_beat_i;
  end

endmodule

`default_nettype wire

//--- tests/bot_tb.sv
`timescale 1ns/10ps
`default_nettype none

module bot_tb;

  localparam int NUM_CBW        = 40;
  localparam int CYCLES_PER_CBW = 400;

  logic                  clock;
  logic                  reset;
  logic                  usb_rx_valid_i;
  logic                  usb_rx_ready_o;
  bot_pkg::stream_beat_t usb_rx_beat_i;
  logic                  usb_tx_valid_o;
  logic                  usb_tx_ready_i;
  bot_pkg::stream_beat_t usb_tx_beat_o;
  logic                  cmd_req_o;
  bot_pkg::scsi_cmd_t    cmd_o;
  logic                  cmd_ack_i;
  logic                  done_req_i;
  bot_pkg::scsi_status_t done_status_i;
  logic                  done_ack_o;
  logic                  error_o;
  logic                  end_check;
  logic [31:0]           rng_state = 32'd47;
  int                    valid_sent = 0;
  int                    csw_count;

  bot_top i_dut (.*);

  bot_checker i_checker (
    .clock          (clock),
    .reset          (reset),
    .usb_rx_valid_i (usb_rx_valid_i),
    .usb_rx_ready_i (usb_rx_ready_o),
    .usb_rx_beat_i  (usb_rx_beat_i),
    .usb_tx_valid_i (usb_tx_valid_o),
    .usb_tx_ready_i (usb_tx_ready_i),
    .usb_tx_beat_i  (usb_tx_beat_o),
    .cmd_req_i      (cmd_req_o),
    .cmd_i          (cmd_o),
    .cmd_ack_i      (cmd_ack_i),
    .done_req_i     (done_req_i),
    .done_status_i  (done_status_i),
    .done_ack_i     (done_ack_o),
    .error_i        (error_o),
    .end_check_i    (end_check)
  );

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // One byte on Bulk-Out with random idle cycles before it
  task automatic send_byte(input logic [7:0] data, input logic last);
    logic taken;
    taken = 1'b0;
    while (xorshift32() % 6 == 0) begin
      usb_rx_valid_i = 1'b0;
      @(posedge clock);
      #1;
    end
    usb_rx_valid_i     = 1'b1;
    usb_rx_beat_i.data = data;
    usb_rx_beat_i.last = last;
    while (!taken) begin
      @(negedge clock);
      taken = usb_rx_ready_o;
      @(posedge clock);
      #1;
    end
    usb_rx_valid_i = 1'b0;
  endtask

  task automatic send_cbw(input logic corrupt);
    logic [7:0]  pkt [0:30];
    logic [31:0] tag;
    logic [31:0] len;
    logic [31:0] r;
    tag = xorshift32();
    len = xorshift32() & 32'h0001_FFFF;
    r   = xorshift32();
    pkt[0] = 8'h55;
    pkt[1] = 8'h53;
    pkt[2] = 8'h42;
    pkt[3] = 8'h43;
    for (int i = 0; i < 4; i++) begin
      pkt[4+i] = tag[8*i +: 8];
      pkt[8+i] = len[8*i +: 8];
    end
    pkt[12] = {r[0], 7'd0};
    pkt[13] = {4'd0, r[4:1]};
    pkt[14] = 8'd1 + 8'(r[9:5] % 16);
    for (int i = 15; i < 31; i++) begin
      pkt[i] = 8'(xorshift32());
    end
    case (r[12:10] % 5)
      0: pkt[15] = 8'h00;
      1: pkt[15] = 8'h12;
      2: pkt[15] = 8'h28;
      3: pkt[15] = 8'h2A;
      default: ;
    endcase
    if (corrupt) begin
      r = xorshift32();
      case (r[1:0])
        2'd0: pkt[r[3:2]] = pkt[r[3:2]] ^ 8'h01;
        2'd1: pkt[12] = pkt[12] | (8'd1 << (r[7:4] % 7));
        2'd2: pkt[13] = pkt[13] | (8'h10 << r[3:2]);
        default: pkt[14] = r[8] ? 8'd0 : 8'd17 + 8'(r[15:9] % 100);
      endcase
    end
    for (int i = 0; i < 31; i++) begin
      send_byte(pkt[i], i == 30);
    end
  endtask

  always @(posedge clock) begin
    if (reset) csw_count <= 0;
    else if (usb_tx_valid_o && usb_tx_ready_i && usb_tx_beat_o.last) csw_count <= csw_count + 1;
  end

  // SCSI controller side of both handshakes
  initial begin : responder
    logic [31:0] r;
    cmd_ack_i     = 1'b0;
    done_req_i    = 1'b0;
    done_status_i = '0;
    forever begin
      @(negedge clock);
      while (!cmd_req_o) @(negedge clock);
      repeat (xorshift32() % 6) @(posedge clock);
      @(posedge clock);
      #1 cmd_ack_i = 1'b1;
      @(negedge clock);
      while (cmd_req_o) @(negedge clock);
      @(posedge clock);
      #1 cmd_ack_i = 1'b0;
      repeat (xorshift32() % 8) @(posedge clock);
      @(posedge clock);
      #1;
      r = xorshift32();
      done_status_i.status      = 8'(r[1:0] % 3);
      done_status_i.transferred = xorshift32() & 32'h0001_FFFF;
      done_req_i = 1'b1;
      @(negedge clock);
      while (!done_ack_o) @(negedge clock);
      @(posedge clock);
      #1 done_req_i = 1'b0;
      @(negedge clock);
      while (done_ack_o) @(negedge clock);
    end
  end

  initial begin
    usb_tx_ready_i = 1'b0;
    forever begin
      @(posedge clock);
      #1 usb_tx_ready_i = xorshift32() % 4 != 0;
    end
  end

  initial begin
    repeat (NUM_CBW * CYCLES_PER_CBW) @(posedge clock);
    $display("Timeout: the run did not finish within %0d cycles", NUM_CBW * CYCLES_PER_CBW);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    reset          = 1'b1;
    usb_rx_valid_i = 1'b0;
    usb_rx_beat_i  = '0;
    end_check      = 1'b0;
    repeat (10) @(posedge clock);
    #1 reset = 1'b0;
    // Every fifth CBW carries one bad field
    for (int n = 0; n < NUM_CBW; n++) begin
      send_cbw(n % 5 == 4);
      if (n % 5 != 4) valid_sent++;
    end
    while (csw_count < valid_sent) @(posedge clock);
    repeat (20) @(posedge clock);
    #1 end_check = 1'b1;
    repeat (2) @(posedge clock);
    $display("Errors: %0d, commands: %0d, rejected CBWs: %0d, CSWs: %0d",
             i_checker.errors, i_checker.cmd_count, i_checker.reject_count, csw_count);
    if (i_checker.errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
